// ==== periph_pkg.sv ====
/*
 * Shared widths, bus structs and the address map of the peripheral subsystem.
 * Regions are base/mask pairs; the mask bits must cover the region's offsets.
 * Board register offsets sit in address bits [5:3], one register per 8 bytes.
 */

package periph_pkg;

    // --------------------------------------------------
    // Bus widths
    // --------------------------------------------------
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned BE_W   = DATA_W / 8;

    // One request per cycle, req is a strobe
    typedef struct packed {
        logic              req;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [BE_W-1:0]   be;
        logic [DATA_W-1:0] wdata;
    } periph_req_t;

    // Response, one cycle after the request
    typedef struct packed {
        logic              rvalid;
        logic              err;
        logic [DATA_W-1:0] rdata;
    } periph_rsp_t;

    // Target picked by the decoder
    typedef enum logic [1:0] {
        REGION_BOOT,
        REGION_BOARD,
        REGION_NONE
    } region_e;

    // --------------------------------------------------
    // Board register block
    // --------------------------------------------------
    localparam int unsigned BOARD_SEL_LSB = 3;
    localparam int unsigned BOARD_SEL_W   = 3;

    typedef enum logic [BOARD_SEL_W-1:0] {
        BOARD_LEDS_DIP      = 3'd0, // W: LEDs, R: DIP switches
        BOARD_FLASH_READOUT = 3'd4, // R: engine readout word
        BOARD_FLASH_CMD     = 3'd5, // W: host word to the engine
        BOARD_FLASH_STATUS  = 3'd6  // R: busy, error
    } board_reg_e;

    // --------------------------------------------------
    // Region map
    // --------------------------------------------------
    localparam logic [ADDR_W-1:0] BOOT_BASE  = 32'h0001_0000;
    localparam logic [ADDR_W-1:0] BOOT_MASK  = 32'h0000_0FFF; // 4 KiB window
    localparam logic [ADDR_W-1:0] BOARD_BASE = 32'h4000_0000;
    localparam logic [ADDR_W-1:0] BOARD_MASK = 32'h0000_0FFF;

    // Unmapped addresses and unused offsets read this
    localparam logic [DATA_W-1:0] FILLER_WORD = 32'hDEADBEEF;

endpackage

// ==== periph_decoder.sv ====
/*
 * Base/mask decode of the host request into per-target strobes.
 * The response comes one cycle later; unmapped addresses answer with the
 * filler word and err set, and no target sees the request.
 */

`timescale 1ns/1ns

module periph_decoder (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  periph_pkg::periph_req_t        req_i,
    input  logic [periph_pkg::DATA_W-1:0]  boot_rdata_i,
    input  logic [periph_pkg::DATA_W-1:0]  board_rdata_i,
    output logic                           boot_req_o,
    output logic                           board_req_o,
    output periph_pkg::periph_rsp_t        rsp_o
);

    import periph_pkg::*;

    region_e region_d;
    region_e region_q; // Region of the request being answered
    logic    valid_q;

    // Address outside the mask must equal the base
    function automatic logic region_hit(
        input logic [ADDR_W-1:0] addr,
        input logic [ADDR_W-1:0] base,
        input logic [ADDR_W-1:0] mask
    );
        return (addr & ~mask) == base;
    endfunction

    // --------------------------------------------------
    // Request cycle
    // --------------------------------------------------
    always_comb
    begin
        if (region_hit(req_i.addr, BOOT_BASE, BOOT_MASK))
        begin
            region_d = REGION_BOOT;
        end
        else if (region_hit(req_i.addr, BOARD_BASE, BOARD_MASK))
        begin
            region_d = REGION_BOARD;
        end
        else
        begin
            region_d = REGION_NONE;
        end
    end

    assign boot_req_o  = req_i.req && (region_d == REGION_BOOT);
    assign board_req_o = req_i.req && (region_d == REGION_BOARD);

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            valid_q  <= 1'b0;
            region_q <= REGION_NONE;
        end
        else
        begin
            valid_q <= req_i.req; // Every request gets a response
            if (req_i.req)
            begin
                region_q <= region_d;
            end
        end
    end

    // --------------------------------------------------
    // Response cycle
    // --------------------------------------------------
    always_comb
    begin
        rsp_o.rvalid = valid_q;
        rsp_o.err    = 1'b0;
        rsp_o.rdata  = FILLER_WORD;
        case (region_q)
            REGION_BOOT:  rsp_o.rdata = boot_rdata_i;
            REGION_BOARD: rsp_o.rdata = board_rdata_i;
            default:      rsp_o.err   = valid_q; // Error responder
        endcase
    end

endmodule

// ==== boot_ram.sv ====
/*
 * Single-port boot RAM with byte enables, word addressed.
 * BOOT_WORDS must be a power of two, at most 1024, so it fits the 4 KiB window.
 * A read of a word written in the same request returns the old content.
 */

`timescale 1ns/1ns

module boot_ram #(
    parameter int unsigned BOOT_WORDS = 256
) (
    input  logic                          clk_i,
    input  logic                          req_i,
    input  logic                          we_i,
    input  logic [periph_pkg::ADDR_W-1:0] addr_i,
    input  logic [periph_pkg::BE_W-1:0]   be_i,
    input  logic [periph_pkg::DATA_W-1:0] wdata_i,
    output logic [periph_pkg::DATA_W-1:0] rdata_o
);

    import periph_pkg::*;

    localparam int unsigned IDX_W  = $clog2(BOOT_WORDS);
    localparam int unsigned OFFS_W = $clog2(BE_W); // Byte offset bits

    logic [DATA_W-1:0] mem [BOOT_WORDS];
    logic [IDX_W-1:0]  idx;

    // Upper address bits wrap modulo the depth
    assign idx = addr_i[OFFS_W +: IDX_W];

    // --------------------------------------------------
    // Byte-enabled write
    // --------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (req_i && we_i)
        begin
            for (int b = 0; b < BE_W; b++)
            begin
                if (be_i[b])
                begin
                    mem[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    // Registered read, on every request
    always_ff @(posedge clk_i)
    begin
        if (req_i)
        begin
            rdata_o <= mem[idx]; // Old word on a same-cycle write
        end
    end

endmodule

// ==== board_io_regs.sv ====
/*
 * Board I/O registers: LEDs, DIP switches and the flash-engine interface.
 * Byte enables are not decoded; writes always take the full word.
 * Read data follows the live inputs in the response cycle.
 */

`timescale 1ns/1ns

module board_io_regs (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          req_i,
    input  logic                          we_i,
    input  logic [periph_pkg::ADDR_W-1:0] addr_i,
    input  logic [periph_pkg::DATA_W-1:0] wdata_i,
    input  logic [7:0]                    dip_i,
    input  logic [periph_pkg::DATA_W-1:0] flash_readout_i,
    input  logic                          flash_busy_i,
    input  logic                          flash_error_i,
    output logic [periph_pkg::DATA_W-1:0] rdata_o,
    output logic [7:0]                    leds_o,
    output logic                          host_wr_o,
    output logic [periph_pkg::DATA_W-1:0] host_data_o
);

    import periph_pkg::*;

    board_reg_e sel;       // Offset of the current request
    board_reg_e rd_sel_q;  // Offset being answered

    assign sel = board_reg_e'(addr_i[BOARD_SEL_LSB +: BOARD_SEL_W]);

    // --------------------------------------------------
    // Write side
    // --------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            leds_o    <= '0;
            host_wr_o <= 1'b0;
        end
        else
        begin
            host_wr_o <= 1'b0; // One-cycle strobe
            if (req_i && we_i)
            begin
                case (sel)
                    BOARD_LEDS_DIP:  leds_o    <= wdata_i[7:0];
                    BOARD_FLASH_CMD: host_wr_o <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // Host word held for the flash engine
    always_ff @(posedge clk_i)
    begin
        if (req_i && we_i && (sel == BOARD_FLASH_CMD))
        begin
            host_data_o <= wdata_i;
        end
    end

    // --------------------------------------------------
    // Read side
    // --------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (req_i)
        begin
            rd_sel_q <= sel;
        end
    end

    always_comb
    begin
        case (rd_sel_q)
            BOARD_LEDS_DIP:      rdata_o = DATA_W'(dip_i);
            BOARD_FLASH_READOUT: rdata_o = flash_readout_i;
            BOARD_FLASH_STATUS:  rdata_o = DATA_W'({flash_busy_i, flash_error_i});
            default:             rdata_o = FILLER_WORD; // Unused offsets, write-only cmd
        endcase
    end

endmodule

// ==== periph_top.sv ====
/*
 * Peripheral subsystem top: one host port fanned out to the boot RAM and
 * the board register block. No back-pressure; every request is answered
 * exactly one cycle later.
 */

`timescale 1ns/1ns

module periph_top #(
    parameter int unsigned BOOT_WORDS = 256
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  periph_pkg::periph_req_t       req_i,
    input  logic [7:0]                    dip_i,
    input  logic [periph_pkg::DATA_W-1:0] flash_readout_i,
    input  logic                          flash_busy_i,
    input  logic                          flash_error_i,
    output periph_pkg::periph_rsp_t       rsp_o,
    output logic [7:0]                    leds_o,
    output logic                          host_wr_o,
    output logic [periph_pkg::DATA_W-1:0] host_data_o
);

    import periph_pkg::*;

    logic              boot_req;
    logic              board_req;
    logic [DATA_W-1:0] boot_rdata;
    logic [DATA_W-1:0] board_rdata;

    // --------------------------------------------------
    // Address decode and response mux
    // --------------------------------------------------
    periph_decoder i_decoder (
        .clk_i         ( clk_i       ),
        .reset_i       ( reset_i     ),
        .req_i         ( req_i       ),
        .boot_rdata_i  ( boot_rdata  ),
        .board_rdata_i ( board_rdata ),
        .boot_req_o    ( boot_req    ),
        .board_req_o   ( board_req   ),
        .rsp_o         ( rsp_o       )
    );

    // Request fields go to both targets, only the strobe differs
    boot_ram #(
        .BOOT_WORDS ( BOOT_WORDS )
    ) i_boot_ram (
        .clk_i   ( clk_i       ),
        .req_i   ( boot_req    ),
        .we_i    ( req_i.we    ),
        .addr_i  ( req_i.addr  ),
        .be_i    ( req_i.be    ),
        .wdata_i ( req_i.wdata ),
        .rdata_o ( boot_rdata  )
    );

    board_io_regs i_board_io (
        .clk_i           ( clk_i           ),
        .reset_i         ( reset_i         ),
        .req_i           ( board_req       ),
        .we_i            ( req_i.we        ),
        .addr_i          ( req_i.addr      ),
        .wdata_i         ( req_i.wdata     ),
        .dip_i           ( dip_i           ),
        .flash_readout_i ( flash_readout_i ),
        .flash_busy_i    ( flash_busy_i    ),
        .flash_error_i   ( flash_error_i   ),
        .rdata_o         ( board_rdata     ),
        .leds_o          ( leds_o          ),
        .host_wr_o       ( host_wr_o       ),
        .host_data_o     ( host_data_o     )
    );

endmodule

// ==== periph_checker.sv ====
/*
 * Timing assertions on the host port of periph_top, bound into the DUT.
 * fail_count sums the failed assertions of all three properties.
 * Back-to-back command writes give back-to-back host_wr_o pulses.
 */

`timescale 1ns/1ns

module periph_checker (
    input logic clk_i,
    input logic reset_i,
    input logic req_valid_i,
    input logic rvalid_i,
    input logic host_wr_i,
    input logic cmd_wr_i    // Write to the flash command offset
);

    int unsigned rvalid_fails  = 0;
    int unsigned host_wr_fails = 0;
    int unsigned reset_fails   = 0;
    int unsigned fail_count;

    assign fail_count = rvalid_fails + host_wr_fails + reset_fails;

    a_rvalid_follows_req: assert property (
        @(posedge clk_i) disable iff (reset_i) rvalid_i == $past(req_valid_i)
    )
    else
    begin
        rvalid_fails++;
        $error("rvalid did not follow a request by exactly one cycle");
    end

    // Two high cycles only as two separate pulses
    a_host_wr_single: assert property (
        @(posedge clk_i) disable iff (reset_i)
            (host_wr_i && $past(host_wr_i)) |-> ($past(cmd_wr_i) && $past(cmd_wr_i, 2))
    )
    else
    begin
        host_wr_fails++;
        $error("host_wr_o stayed high for two cycles without two command writes");
    end

    a_rvalid_low_in_reset: assert property (
        @(posedge clk_i) (reset_i && $past(reset_i)) |-> !rvalid_i
    )
    else
    begin
        reset_fails++;
        $error("rvalid high during reset");
    end

endmodule

bind periph_top periph_checker i_checker (
    .clk_i       ( clk_i        ),
    .reset_i     ( reset_i      ),
    .req_valid_i ( req_i.req    ),
    .rvalid_i    ( rsp_o.rvalid ),
    .host_wr_i   ( host_wr_o    ),
    .cmd_wr_i    ( board_req && req_i.we &&
                   (req_i.addr[periph_pkg::BOARD_SEL_LSB +: periph_pkg::BOARD_SEL_W]
                    == periph_pkg::BOARD_FLASH_CMD) )
);

// ==== periph_monitor.sv ====
/*
 * Reference model and comparator for periph_top, sampled on the falling edge.
 * A RAM word counts as known only once fully written; other reads are skipped.
 */

`timescale 1ns/1ns

module periph_monitor #(
    parameter int unsigned BOOT_WORDS = 256
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  periph_pkg::periph_req_t       req_i,
    input  periph_pkg::periph_rsp_t       rsp_i,
    input  logic [7:0]                    leds_i,
    input  logic                          host_wr_i,
    input  logic [periph_pkg::DATA_W-1:0] host_data_i,
    input  logic [7:0]                    dip_i,
    input  logic [periph_pkg::DATA_W-1:0] flash_readout_i,
    input  logic                          flash_busy_i,
    input  logic                          flash_error_i,
    output int unsigned                   error_count_o,
    output int unsigned                   check_count_o
);

    import periph_pkg::*;

    logic [DATA_W-1:0] ram_model [BOOT_WORDS];
    logic              ram_known [BOOT_WORDS];
    logic [7:0]        leds_model;
    logic              host_wr_model;   // Pulse expected this cycle
    logic [DATA_W-1:0] host_word_model;
    logic              host_word_known;
    int unsigned       errors = 0;
    int unsigned       checks = 0;

    // Request waiting for its response
    logic              pend_valid;
    logic              pend_we;
    region_e           pend_region;
    logic [2:0]        pend_off;
    logic [DATA_W-1:0] pend_ram_word;   // Content before the write
    logic              pend_ram_known;

    assign error_count_o = errors;
    assign check_count_o = checks;

    task automatic compare(input string name, input logic [DATA_W-1:0] exp,
                           input logic [DATA_W-1:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("** Error [%s] expected %h actual %h", name, exp, act);
        end
    endtask

    function automatic region_e region_of(input logic [ADDR_W-1:0] addr);
        if ((addr & ~BOOT_MASK) == BOOT_BASE)
            return REGION_BOOT;
        if ((addr & ~BOARD_MASK) == BOARD_BASE)
            return REGION_BOARD;
        return REGION_NONE;
    endfunction

    // Live inputs of the response cycle
    function automatic logic [DATA_W-1:0] board_value(input logic [2:0] off);
        case (off)
            BOARD_LEDS_DIP:      return {24'h0, dip_i};
            BOARD_FLASH_READOUT: return flash_readout_i;
            BOARD_FLASH_STATUS:  return {30'h0, flash_busy_i, flash_error_i};
            default:             return FILLER_WORD;
        endcase
    endfunction

    task automatic check_response();
        compare("rvalid", DATA_W'(pend_valid), DATA_W'(rsp_i.rvalid));
        if (pend_valid)
        begin
            compare("err", DATA_W'(pend_region == REGION_NONE), DATA_W'(rsp_i.err));
            if (!pend_we && pend_region == REGION_BOOT && pend_ram_known)
                compare("boot_ram read", pend_ram_word, rsp_i.rdata);
            else if (!pend_we && pend_region == REGION_BOARD)
                compare("board read", board_value(pend_off), rsp_i.rdata);
            else if (!pend_we && pend_region == REGION_NONE)
                compare("unmapped read", FILLER_WORD, rsp_i.rdata);
        end
    endtask

    task automatic accept_request();
        int unsigned idx;
        idx            = (req_i.addr >> $clog2(BE_W)) % BOOT_WORDS;
        host_wr_model  = 1'b0;
        pend_valid     = req_i.req;
        pend_we        = req_i.we;
        pend_region    = region_of(req_i.addr);
        pend_off       = req_i.addr[BOARD_SEL_LSB +: BOARD_SEL_W];
        pend_ram_word  = ram_model[idx];
        pend_ram_known = ram_known[idx];
        if (req_i.req && req_i.we && pend_region == REGION_BOOT)
        begin
            for (int b = 0; b < BE_W; b++)
                if (req_i.be[b])
                    ram_model[idx][b*8 +: 8] = req_i.wdata[b*8 +: 8];
            ram_known[idx] = ram_known[idx] || (req_i.be == '1);
        end
        if (req_i.req && req_i.we && pend_region == REGION_BOARD)
        begin
            if (pend_off == BOARD_LEDS_DIP)
                leds_model = req_i.wdata[7:0];
            if (pend_off == BOARD_FLASH_CMD)
            begin
                host_wr_model   = 1'b1;
                host_word_model = req_i.wdata;
                host_word_known = 1'b1;
            end
        end
    endtask

    // --------------------------------------------------
    // Check last cycle's results, then take the new request
    // --------------------------------------------------
    always @(negedge clk_i)
    begin
        if (reset_i)
        begin
            leds_model      = '0;
            host_wr_model   = 1'b0;
            host_word_known = 1'b0;
            pend_valid      = 1'b0;
            for (int i = 0; i < BOOT_WORDS; i++)
                ram_known[i] = 1'b0;
        end
        else
        begin
            check_response();
            compare("leds", DATA_W'(leds_model), DATA_W'(leds_i));
            compare("host_wr", DATA_W'(host_wr_model), DATA_W'(host_wr_i));
            if (host_word_known)
                compare("host_data", host_word_model, host_data_i);
            accept_request();
        end
    end

endmodule

// ==== tb_periph.sv ====
/*
 * Testbench for periph_top: RAM fill, seeded random traffic, then a read sweep.
 * All comparing is done in periph_monitor; periph_checker is bound into the DUT.
 */

`timescale 1ns/1ns

module tb_periph;

    import periph_pkg::*;

    localparam int unsigned BOOT_WORDS  = 256;
    localparam int unsigned N_RANDOM    = 2000;
    localparam int unsigned N_CYCLES    = 16 + BOOT_WORDS + N_RANDOM + BOOT_WORDS + 8 + 4;
    localparam int unsigned WATCHDOG_NS = N_CYCLES * 4 + 200;

    logic              clk;
    logic              reset;
    periph_req_t       req;
    periph_rsp_t       rsp;
    logic [7:0]        dip;
    logic [DATA_W-1:0] flash_readout;
    logic              flash_busy;
    logic              flash_error;
    logic [7:0]        leds;
    logic              host_wr;
    logic [DATA_W-1:0] host_data;
    int unsigned       error_count;
    int unsigned       check_count;
    integer            seed;

    periph_top #(
        .BOOT_WORDS ( BOOT_WORDS )
    ) dut (
        .clk_i           ( clk           ),
        .reset_i         ( reset         ),
        .req_i           ( req           ),
        .dip_i           ( dip           ),
        .flash_readout_i ( flash_readout ),
        .flash_busy_i    ( flash_busy    ),
        .flash_error_i   ( flash_error   ),
        .rsp_o           ( rsp           ),
        .leds_o          ( leds          ),
        .host_wr_o       ( host_wr       ),
        .host_data_o     ( host_data     )
    );

    periph_monitor #(
        .BOOT_WORDS ( BOOT_WORDS )
    ) i_monitor (
        .clk_i           ( clk           ),
        .reset_i         ( reset         ),
        .req_i           ( req           ),
        .rsp_i           ( rsp           ),
        .leds_i          ( leds          ),
        .host_wr_i       ( host_wr       ),
        .host_data_i     ( host_data     ),
        .dip_i           ( dip           ),
        .flash_readout_i ( flash_readout ),
        .flash_busy_i    ( flash_busy    ),
        .flash_error_i   ( flash_error   ),
        .error_count_o   ( error_count   ),
        .check_count_o   ( check_count   )
    );

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // Boot 7/16, board 6/16, unmapped 3/16
    function automatic logic [ADDR_W-1:0] pick_addr(input logic [31:0] r);
        logic [ADDR_W-1:0] offs;
        offs = {20'h0, r[15:4]};
        if (r[3:0] < 4'd7)
            return BOOT_BASE | offs;
        else if (r[3:0] < 4'd13)
            return BOARD_BASE | offs;
        else if (r[16])
            return BOOT_BASE + 32'h0000_1000 + offs; // Just past the boot window
        else
            return {1'b1, r[30:0]};
    endfunction

    // One host cycle, with fresh DIP and flash-engine inputs
    task automatic drive_cycle(input logic valid, input logic we,
                               input logic [ADDR_W-1:0] addr, input logic [BE_W-1:0] be,
                               input logic [DATA_W-1:0] wdata);
        logic [31:0] r;
        @(posedge clk);
        #1;
        r             = rand_word();
        req.req       = valid;
        req.we        = we;
        req.addr      = addr;
        req.be        = be;
        req.wdata     = wdata;
        dip           = r[7:0];
        flash_busy    = r[8];
        flash_error   = r[9];
        flash_readout = rand_word();
    endtask

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial
    begin
        logic [31:0] r;
        logic [31:0] a;
        seed          = 32'h3481_d5df;
        reset         = 1'b1;
        req           = '0;
        dip           = '0;
        flash_readout = '0;
        flash_busy    = 1'b0;
        flash_error   = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < BOOT_WORDS; i++)
            drive_cycle(1'b1, 1'b1, BOOT_BASE | ADDR_W'(i << 2), '1, rand_word());
        for (int i = 0; i < N_RANDOM; i++)
        begin
            r = rand_word();
            a = rand_word();
            drive_cycle(r[2:0] != 3'd0, r[3], pick_addr(a), r[7:4], rand_word());
        end
        // Read back every RAM word and every register offset
        for (int i = 0; i < BOOT_WORDS; i++)
            drive_cycle(1'b1, 1'b0, BOOT_BASE | ADDR_W'(i << 2), '0, '0);
        for (int i = 0; i < 8; i++)
            drive_cycle(1'b1, 1'b0, BOARD_BASE | ADDR_W'(i << BOARD_SEL_LSB), '0, '0);
        repeat (4) drive_cycle(1'b0, 1'b0, '0, '0, '0);
        @(negedge clk);
        $display("Summary: %0d checks, %0d mismatches, %0d assertion failures",
                 check_count, error_count, dut.i_checker.fail_count);
        if (error_count == 0 && dut.i_checker.fail_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== build.f ====
periph_pkg.sv
periph_decoder.sv
boot_ram.sv
board_io_regs.sv
periph_top.sv
periph_checker.sv
periph_monitor.sv
tb_periph.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_periph
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ns
FAIL_MSG  ?= Checks failed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# A crash or assertion stop also counts as failure
sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
